// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_core
FILELIST  = files.f
STIMULUS  = verif/program_stimulus.hex
LOG       = sim.log
FAIL_MSG  = Testbench failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) $(STIMULUS)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: common/pipe_if.sv
`timescale 1ns/1ps

// Interfaces between the pipeline stages and to the register bank.
// Payloads carry no handshake; an OP_NOP payload is a bubble.

interface dec_exe_if;
    rv_pkg::op_e       op;
    rv_pkg::word_t     first_operand;
    rv_pkg::word_t     second_operand;
    rv_pkg::word_t     store_data;     // Store data or branch compare value.
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     pc;
    rv_pkg::tag_t      tag;

    modport producer (output op, first_operand, second_operand, store_data, rd, pc, tag);
    modport consumer (input  op, first_operand, second_operand, store_data, rd, pc, tag);
endinterface

interface exe_ret_if;
    rv_pkg::op_e       op;
    rv_pkg::word_t     result;         // ALU result or memory address.
    rv_pkg::word_t     store_data;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     target;
    logic              taken;
    rv_pkg::tag_t      tag;

    modport producer (output op, result, store_data, rd, target, taken, tag);
    modport consumer (input  op, result, store_data, rd, target, taken, tag);
endinterface

interface regfile_if;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::word_t     data1;
    rv_pkg::word_t     data2;
    logic              write_enable;
    rv_pkg::reg_addr_t write_addr;
    rv_pkg::word_t     write_data;

    modport reader (output rs1, rs2, input data1, data2);
    modport writer (output write_enable, write_addr, write_data);
    modport bank   (input rs1, rs2, write_enable, write_addr, write_data, output data1, data2);
endinterface

// File: common/rv_pkg.sv
// Shared definitions for the four-stage RV32I subset core.
// Holds the data widths, the major opcodes, the executed
// operation set and the first fetch address.

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;   // Kill tag width, wraps freely.

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0]      tag_t;

    localparam word_t RESET_VECTOR = 32'h0000_0000;

    // Major opcodes of the supported encodings.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Operations carried down the pipeline. OP_NOP doubles as the bubble.
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE
    } op_e;

endpackage

// File: files.f
common/rv_pkg.sv
common/pipe_if.sv
src/fetch.sv
src/decode.sv
src/regbank.sv
src/execute.sv
src/retire.sv
src/rv_core.sv
verif/rv_core_props.sv
verif/rv_checker.sv
verif/tb_rv_core.sv

// File: src/decode.sv
`timescale 1ns/1ps

// Decode stage. Maps the instruction word to an operation, picks the
// operands, inserts a bubble when the instruction in execute writes a
// source register, and keeps the word it could not pass on.

module decode (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    input  rv_pkg::word_t instruction_i,
    input  rv_pkg::word_t pc_i,
    input  rv_pkg::tag_t  tag_i,
    regfile_if.reader     rf,
    dec_exe_if.producer   out,
    output logic          hazard_o
);

    rv_pkg::word_t     held_word;
    logic              use_held;
    rv_pkg::word_t     instr;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv_pkg::op_e       op;
    rv_pkg::word_t     second_operand;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_s;
    rv_pkg::word_t     imm_b;
    rv_pkg::word_t     imm_u;
    logic              reads_rs2;
    logic              writes_rd;

    assign instr  = use_held ? held_word : instruction_i;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation decode. Anything outside the subset becomes a bubble.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        op = rv_pkg::OP_NOP;
        case (opcode)
            rv_pkg::OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = rv_pkg::OP_ADD;
                        3'b010:  op = rv_pkg::OP_SLT;
                        3'b100:  op = rv_pkg::OP_XOR;
                        3'b110:  op = rv_pkg::OP_OR;
                        3'b111:  op = rv_pkg::OP_AND;
                        default: op = rv_pkg::OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = rv_pkg::OP_SUB;
                end
            end
            rv_pkg::OPC_OPIMM:  if (funct3 == 3'b000) op = rv_pkg::OP_ADD;
            rv_pkg::OPC_LUI:    op = rv_pkg::OP_ADD;   // Becomes x0 plus the upper immediate.
            rv_pkg::OPC_LOAD:   if (funct3 == 3'b010) op = rv_pkg::OP_LW;
            rv_pkg::OPC_STORE:  if (funct3 == 3'b010) op = rv_pkg::OP_SW;
            rv_pkg::OPC_BRANCH: begin
                if (funct3 == 3'b000) op = rv_pkg::OP_BEQ;
                if (funct3 == 3'b001) op = rv_pkg::OP_BNE;
            end
            default: op = rv_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::OPC_OPIMM,
            rv_pkg::OPC_LOAD:   second_operand = imm_i;
            rv_pkg::OPC_STORE:  second_operand = imm_s;
            rv_pkg::OPC_BRANCH: second_operand = imm_b;   // Execute adds it to the pc.
            rv_pkg::OPC_LUI:    second_operand = imm_u;
            default:            second_operand = rf.data2;
        endcase
    end

    // Unused source fields read x0, which never causes a hazard.
    assign reads_rs2 = (op != rv_pkg::OP_NOP) &&
                       (opcode == rv_pkg::OPC_OP || opcode == rv_pkg::OPC_STORE ||
                        opcode == rv_pkg::OPC_BRANCH);
    assign writes_rd = (op != rv_pkg::OP_NOP) && (op != rv_pkg::OP_SW) &&
                       (op != rv_pkg::OP_BEQ) && (op != rv_pkg::OP_BNE);

    assign rf.rs1 = (op != rv_pkg::OP_NOP && opcode != rv_pkg::OPC_LUI) ? instr[19:15] : '0;
    assign rf.rs2 = reads_rs2 ? instr[24:20] : '0;

    assign hazard_o = (out.rd != '0) && (rf.rs1 == out.rd || rf.rs2 == out.rd);

    // The first cycle after reset has no fetched word yet, so decode
    // starts from an all-zero held word that decodes to a bubble.
    always_ff @(posedge clk) begin
        if (reset) begin
            use_held  <= 1'b1;
            held_word <= '0;
            out.op    <= rv_pkg::OP_NOP;
            out.rd    <= '0;
            out.tag   <= '0;
        end else begin
            use_held  <= stall_i | hazard_o;
            held_word <= instr;
            if (!stall_i) begin
                out.op  <= hazard_o ? rv_pkg::OP_NOP : op;
                out.rd  <= (hazard_o || !writes_rd) ? '0 : instr[11:7];
                out.tag <= tag_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            out.first_operand  <= rf.data1;
            out.second_operand <= second_operand;
            out.store_data     <= rf.data2;
            out.pc             <= pc_i;
        end
    end

endmodule

// File: src/execute.sv
`timescale 1ns/1ps

// Execute stage. Runs the ALU, resolves the branch condition and
// target, issues the load request and registers the result for retire.

module execute (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    dec_exe_if.consumer   in,
    exe_ret_if.producer   out,
    output logic          mem_read_o,
    output rv_pkg::word_t mem_read_address_o
);

    rv_pkg::word_t sum;
    rv_pkg::word_t result;
    logic          equal;
    logic          taken;

    assign sum   = in.first_operand + in.second_operand;   // Also the load/store address.
    assign equal = (in.first_operand == in.store_data);

    always_comb begin
        case (in.op)
            rv_pkg::OP_SUB: result = in.first_operand - in.second_operand;
            rv_pkg::OP_AND: result = in.first_operand & in.second_operand;
            rv_pkg::OP_OR:  result = in.first_operand | in.second_operand;
            rv_pkg::OP_XOR: result = in.first_operand ^ in.second_operand;
            rv_pkg::OP_SLT: begin
                result = {{(rv_pkg::XLEN-1){1'b0}},
                          $signed(in.first_operand) < $signed(in.second_operand)};
            end
            default:        result = sum;
        endcase
    end

    assign taken = (in.op == rv_pkg::OP_BEQ &&  equal) ||
                   (in.op == rv_pkg::OP_BNE && !equal);

    // The read goes out now and its data is back while the load retires.
    assign mem_read_o         = (in.op == rv_pkg::OP_LW);
    assign mem_read_address_o = sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            out.op    <= rv_pkg::OP_NOP;
            out.rd    <= '0;
            out.taken <= 1'b0;
            out.tag   <= '0;
        end else if (!stall_i) begin
            out.op    <= in.op;
            out.rd    <= in.rd;
            out.taken <= taken;
            out.tag   <= in.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            out.result     <= result;
            out.store_data <= in.store_data;
            out.target     <= in.pc + in.second_operand;
        end
    end

endmodule

// File: src/fetch.sv
`timescale 1ns/1ps

// Fetch stage. Owns the program counter, follows jumps from retire
// and hands the address and kill tag of each fetched word to decode.

module fetch (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    input  logic          hazard_i,
    input  logic          jump_i,
    input  rv_pkg::word_t jump_target_i,
    output rv_pkg::word_t instruction_address_o,
    output rv_pkg::word_t pc_o,
    output rv_pkg::tag_t  tag_o
);

    rv_pkg::tag_t fetch_tag;   // Tag given to words fetched from now on.

    always_ff @(posedge clk) begin
        if (reset) begin
            instruction_address_o <= rv_pkg::RESET_VECTOR;
            pc_o                  <= rv_pkg::RESET_VECTOR;
            tag_o                 <= '0;
            fetch_tag             <= '0;
        end else if (!stall_i) begin
            if (jump_i) begin
                instruction_address_o <= jump_target_i;
                fetch_tag             <= fetch_tag + 1'b1;
            end else if (!hazard_i) begin
                instruction_address_o <= instruction_address_o + 32'd4;
            end
            // The word for the current address reaches decode next cycle.
            if (!hazard_i) begin
                pc_o  <= instruction_address_o;
                tag_o <= fetch_tag;   // Old tag, so the wrong path gets killed.
            end
        end
    end

endmodule

// File: src/regbank.sv
`timescale 1ns/1ps

// General register bank, x1 to x31, with x0 tied to zero.
// Two combinational read ports see a same-cycle write directly.

module regbank (
    input  logic    clk,
    input  logic    reset,
    regfile_if.bank rf
);

    rv_pkg::word_t regs [1:31];

    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t idx);
        if (idx == '0) return '0;
        if (rf.write_enable && rf.write_addr == idx) return rf.write_data;   // Write-back bypass.
        return regs[idx];
    endfunction

    always_comb begin
        rf.data1 = read_port(rf.rs1);
        rf.data2 = read_port(rf.rs2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.write_enable && rf.write_addr != '0) begin
            regs[rf.write_addr] <= rf.write_data;
        end
    end

endmodule

// File: src/retire.sv
`timescale 1ns/1ps

// Retire stage. Drops wrong-path instructions by tag, writes results
// back, issues stores and raises the jump for taken branches.

module retire (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    exe_ret_if.consumer   in,
    input  rv_pkg::word_t mem_data_i,
    regfile_if.writer     rf,
    output logic [3:0]    mem_write_enable_o,
    output rv_pkg::word_t mem_write_address_o,
    output rv_pkg::word_t mem_data_o,
    output logic          jump_o,
    output rv_pkg::word_t jump_target_o
);

    rv_pkg::tag_t current_tag;
    logic         live;

    assign live = (in.tag == current_tag);   // A stale tag marks the wrong path.

    // Decode leaves rd at zero for stores, branches and bubbles.
    assign rf.write_enable = live && (in.rd != '0);
    assign rf.write_addr   = in.rd;
    assign rf.write_data   = (in.op == rv_pkg::OP_LW) ? mem_data_i : in.result;

    assign mem_write_enable_o  = (live && in.op == rv_pkg::OP_SW) ? 4'b1111 : 4'b0000;
    assign mem_write_address_o = in.result;
    assign mem_data_o          = in.store_data;

    assign jump_o        = live && in.taken;
    assign jump_target_o = in.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_tag <= '0;
        end else if (jump_o && !stall_i) begin
            current_tag <= current_tag + 1'b1;   // Fetch steps its tag on the same edge.
        end
    end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

// Top level of the four-stage RV32I subset core.
// Connects fetch, decode, execute, retire and the register bank, and
// merges the load and store sides onto one data memory port.

module rv_core (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    input  rv_pkg::word_t instruction_i,
    input  rv_pkg::word_t mem_data_i,
    output rv_pkg::word_t instruction_address_o,
    output logic          mem_operation_enable_o,
    output logic [3:0]    mem_write_enable_o,
    output rv_pkg::word_t mem_address_o,
    output rv_pkg::word_t mem_data_o
);

    logic          hazard;
    logic          jump;
    logic          mem_read;
    rv_pkg::word_t jump_target;
    rv_pkg::word_t pc_decode;
    rv_pkg::word_t mem_read_address;
    rv_pkg::word_t mem_write_address;
    rv_pkg::tag_t  tag_decode;

    dec_exe_if dec_exe ();
    exe_ret_if exe_ret ();
    regfile_if rf ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch fetch_i (
        .clk                   (clk),
        .reset                 (reset),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode),
        .tag_o                 (tag_decode)
    );

    decode decode_i (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .tag_i         (tag_decode),
        .rf            (rf.reader),
        .out           (dec_exe.producer),
        .hazard_o      (hazard)
    );

    regbank regbank_i (
        .clk   (clk),
        .reset (reset),
        .rf    (rf.bank)
    );

    execute execute_i (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall_i),
        .in                 (dec_exe.consumer),
        .out                (exe_ret.producer),
        .mem_read_o         (mem_read),
        .mem_read_address_o (mem_read_address)
    );

    retire retire_i (
        .clk                 (clk),
        .reset               (reset),
        .stall_i             (stall_i),
        .in                  (exe_ret.consumer),
        .mem_data_i          (mem_data_i),
        .rf                  (rf.writer),
        .mem_write_enable_o  (mem_write_enable_o),
        .mem_write_address_o (mem_write_address),
        .mem_data_o          (mem_data_o),
        .jump_o              (jump),
        .jump_target_o       (jump_target)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared data port. A store in retire takes the port over a load.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (mem_write_enable_o != 4'b0000) begin
            mem_address_o = {mem_write_address[rv_pkg::XLEN-1:2], 2'b00};
        end else begin
            mem_address_o = {mem_read_address[rv_pkg::XLEN-1:2], 2'b00};
        end
        mem_operation_enable_o = (mem_write_enable_o != 4'b0000) || mem_read;
    end

endmodule

// File: verif/program_stimulus.hex
// Program word count, program words, then expected store count and
// expected store address/data pairs, all in hex.
1d
// ALU operations and their stores.
01900093 ffa00113 002081b3 40208233 0020f2b3 0020e333 0020c3b3 00112433
123454b7 00302023 00402223 00502423 00602623 00702823 00802a23 00902c23
// Load with dependent add, then BEQ over two stores and a not-taken BNE.
00202e23 06400513 01c02583 00a58633 02c02023 00108663 02102223 02202423
00109463 02a02623 05500693 02d02823 00000063
0b
00000000 00000013
00000004 0000001f
00000008 00000018
0000000c fffffffb
00000010 ffffffe3
00000014 00000001
00000018 12345000
0000001c fffffffa
00000020 0000005e
0000002c 00000064
00000030 00000055

// File: verif/rv_checker.sv
`timescale 1ns/1ps

// Store checker for the core testbench.
// Compares each accepted store with the next expected address/data pair.

module rv_checker (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    input  logic          mem_operation_enable_i,
    input  logic [3:0]    mem_write_enable_i,
    input  rv_pkg::word_t mem_address_i,
    input  rv_pkg::word_t mem_data_i,
    input  rv_pkg::word_t exp_addr_i [0:31],
    input  rv_pkg::word_t exp_data_i [0:31],
    input  int            exp_count_i,
    input  int            run_index_i,
    output int            store_count_o,
    output int            error_count_o
);

    logic store_accepted;
    int   errors = 0;

    assign store_accepted = mem_operation_enable_i && !stall_i && (mem_write_enable_i != 4'b0000);
    assign error_count_o  = errors;

    always @(posedge clk) begin
        if (reset) begin
            store_count_o <= 0;   // Errors survive reset, the store count does not.
        end else if (store_accepted) begin
            if (mem_write_enable_i != 4'b1111) begin
                $display("Store %0d of run %0d is not a full word, byte enables %b",
                         store_count_o, run_index_i, mem_write_enable_i);
                errors <= errors + 1;
            end else if (store_count_o >= exp_count_i) begin
                $display("Unexpected extra store in run %0d: data %h to address %h",
                         run_index_i, mem_data_i, mem_address_i);
                errors <= errors + 1;
            end else if (mem_address_i != exp_addr_i[store_count_o[4:0]] ||
                         mem_data_i != exp_data_i[store_count_o[4:0]]) begin
                $display("[FAIL] run%0d_store%0d: expected %h @ %h, actual %h @ %h",
                         run_index_i, store_count_o,
                         exp_data_i[store_count_o[4:0]], exp_addr_i[store_count_o[4:0]],
                         mem_data_i, mem_address_i);
                errors <= errors + 1;
            end
            store_count_o <= store_count_o + 1;
        end
    end

endmodule

// File: verif/rv_core_props.sv
`timescale 1ns/1ps

// Reset and memory port properties of the core, bound into rv_core.

module rv_core_props (
    input logic          clk,
    input logic          reset,
    input logic          stall_i,
    input rv_pkg::word_t instruction_address_i,
    input logic          mem_operation_enable_i,
    input logic [3:0]    mem_write_enable_i,
    input rv_pkg::word_t mem_address_i
);

    int failures = 0;   // Number of failed property checks so far.

    reset_vector_after_release: assert property (@(posedge clk)
        $fell(reset) |-> instruction_address_i == rv_pkg::RESET_VECTOR)
        else begin
            $error("Fetch address is not the reset vector after reset release.");
            failures++;
        end

    quiet_port_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !mem_operation_enable_i && mem_write_enable_i == 4'b0000)
        else begin
            $error("Data port is active during reset.");
            failures++;
        end

    aligned_address: assert property (@(posedge clk) disable iff (reset)
        mem_address_i[1:0] == 2'b00)
        else begin
            $error("Data address is not word aligned.");
            failures++;
        end

    // A stalled cycle must not move the fetch address.
    stall_holds_fetch: assert property (@(posedge clk) disable iff (reset)
        stall_i |=> $stable(instruction_address_i))
        else begin
            $error("Fetch address moved during a stall.");
            failures++;
        end

endmodule

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps

// Testbench for the four-stage core. Models instruction and data
// memory, loads the program and expected stores from the stimulus
// file, and runs the program once plainly and once under random stall.

module tb_rv_core;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int STORE_TIMEOUT = 4000;   // Cycles allowed for all stores of one run.
    localparam int SETTLE_CYCLES = 60;

    logic          clk           = 1'b0;
    logic          reset         = 1'b1;
    logic          stall_i       = 1'b0;
    rv_pkg::word_t instruction_i = '0;
    rv_pkg::word_t mem_data_i    = '0;
    rv_pkg::word_t instruction_address_o;
    logic          mem_operation_enable_o;
    logic [3:0]    mem_write_enable_o;
    rv_pkg::word_t mem_address_o;
    rv_pkg::word_t mem_data_o;

    rv_pkg::word_t stim [0:127];
    rv_pkg::word_t imem [0:63];
    rv_pkg::word_t dmem [0:63];
    rv_pkg::word_t exp_addr [0:31];
    rv_pkg::word_t exp_data [0:31];
    int            exp_count = 0;
    int            run_index = 0;
    int            store_count;
    int            checker_errors;
    int            assert_errors;
    int            timeout_errors = 0;
    int            tests_failed = 0;
    logic          random_stall = 1'b0;
    logic [31:0]   rnd_state = 32'h77d2_cec3;
    logic [7:0]    phase_cycle = '0;

    rv_core dut_i (.*);

    rv_checker checker_i (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall_i),
        .mem_operation_enable_i (mem_operation_enable_o),
        .mem_write_enable_i     (mem_write_enable_o),
        .mem_address_i          (mem_address_o),
        .mem_data_i             (mem_data_o),
        .exp_addr_i             (exp_addr),
        .exp_data_i             (exp_data),
        .exp_count_i            (exp_count),
        .run_index_i            (run_index),
        .store_count_o          (store_count),
        .error_count_o          (checker_errors)
    );

    bind rv_core rv_core_props props_i (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall_i),
        .instruction_address_i  (instruction_address_o),
        .mem_operation_enable_i (mem_operation_enable_o),
        .mem_write_enable_i     (mem_write_enable_o),
        .mem_address_i          (mem_address_o)
    );

    assign assert_errors = dut_i.props_i.failures;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic rv_pkg::word_t fill_word(input int idx);
        return 32'hc0de_0000 | (idx << 2);   // Byte address in the low half.
    endfunction

    // Store mismatches, missing stores and failed properties together.
    function automatic int error_total();
        return checker_errors + timeout_errors + assert_errors;
    endfunction

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        instruction_i <= imem[instruction_address_o[7:2]];   // One cycle behind the address.
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i[5:0]] <= fill_word(i);
            end
            mem_data_i <= '0;
        end else if (mem_operation_enable_o && !stall_i) begin
            if (mem_write_enable_o != 4'b0000) begin
                dmem[mem_address_o[7:2]] <= mem_data_o;
            end else begin
                mem_data_i <= dmem[mem_address_o[7:2]];
            end
        end
    end

    // Stall alternates between light and heavy phases of 16 cycles.
    always @(posedge clk) begin
        if (reset || !random_stall) begin
            stall_i <= 1'b0;
        end else begin
            rnd_state   <= xorshift32(rnd_state);
            phase_cycle <= phase_cycle + 8'd1;
            if (phase_cycle[4]) begin
                stall_i <= (rnd_state[2:0] != 3'b000);
            end else begin
                stall_i <= (rnd_state[2:0] == 3'b000);
            end
        end
    end

    task automatic load_program();
        int n;
        int base;
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = '0;   // Zero words decode to bubbles.
        end
        n = int'(stim[0]);
        for (int i = 0; i < n; i++) begin
            imem[i[5:0]] = stim[i[6:0] + 7'd1];
        end
        base = n + 1;
        exp_count = int'(stim[base[6:0]]);
        for (int i = 0; i < exp_count; i++) begin
            exp_addr[i[4:0]] = stim[7'(base + 1 + 2 * i)];
            exp_data[i[4:0]] = stim[7'(base + 2 + 2 * i)];
        end
    endtask

    task automatic run_program(input string name, input logic use_stall);
        int errors_before;
        int cycles;
        errors_before = error_total();
        @(posedge clk);
        reset        <= 1'b1;
        random_stall <= use_stall;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        while (store_count < exp_count && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (store_count < exp_count) begin
            $display("Timeout in %s: only %0d of %0d expected stores were seen",
                     name, store_count, exp_count);
            timeout_errors++;
        end
        // Extra time in the final loop catches stores that should never come.
        cycles = 0;
        while (cycles < SETTLE_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (error_total() == errors_before) begin
            $display("Test %s: ok, %0d stores matched", name, store_count);
        end else begin
            $display("Test %s: failed with %0d errors", name,
                     error_total() - errors_before);
            tests_failed++;
        end
        run_index++;
    endtask

    initial begin
        $readmemh("verif/program_stimulus.hex", stim);
        load_program();
        run_program("no_stall", 1'b0);
        run_program("random_stall", 1'b1);
        $display("Tests run: 2, failed: %0d, errors: %0d",
                 tests_failed, error_total());
        if (tests_failed == 0 && error_total() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
